// File: top_of_tops.f
hdl/dbg_pkg.sv
hdl/mem_block.sv
hdl/register_bank.sv
hdl/data_path.sv
hdl/debug_unit.sv
hdl/top_of_tops.sv
tb/top_of_tops_checker.sv
tb/tb_top_of_tops.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top_of_tops
FILELIST  = top_of_tops.f
BUILD_DIR = obj_dir
SIM_LOG   = sim.log
PASS_MSG  = Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(SIM_LOG)
	grep -q "^$(PASS_MSG)$$" $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

// File: tb/tb_top_of_tops.sv
`timescale 1ns/1ps

module tb_top_of_tops
    import dbg_pkg::*;
();

    localparam int WATCHDOG_CYCLES = 5 * 300 * 30;

    logic                clock;
    logic                rst_n;
    logic                rx_done;
    logic [NB_BYTE-1:0]  rx_data;
    logic                tx_done;
    logic [NB_STATE-1:0] state;
    logic [NB_BYTE-1:0]  tx_data;
    logic                tx_start;

    logic [NB_BYTE-1:0]  dump_q [$];
    int                  max_delay;
    int                  test_errs;
    int                  n_pass;
    int                  n_fail;

    // reference model state persists across tests like the DUT
    instr_t              m_imem [2**IM_AW];
    word_t               m_regs [2**RB_AW];
    word_t               m_dmem [2**DM_AW];
    int                  m_pc;

    top_of_tops i_top_of_tops (
        .i_clock    (clock),
        .i_rst_n    (rst_n),
        .i_rx_done  (rx_done),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .o_state    (state),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // answers each start pulse after a random delay, collects the bytes
    initial begin : tx_responder
        int delay;
        forever begin
            @(negedge clock);
            if (tx_start) begin
                dump_q.push_back(tx_data);
                delay = $urandom_range(max_delay, 1);
                repeat (delay) @(posedge clock);
                #1;
                tx_done = 1'b1;
                @(posedge clock);
                #1;
                tx_done = 1'b0;
            end
        end
    end

    function automatic instr_t enc(input logic [5:0] op, input int rs, input int rt,
                                   input int imm);
        instr_t ins;
        ins.op  = op;
        ins.rs  = rs[RB_AW-1:0];
        ins.rt  = rt[RB_AW-1:0];
        ins.imm = imm[15:0];
        return ins;
    endfunction

    task automatic model_step();
        instr_t ins;
        word_t  ea;
        ins = m_imem[m_pc[IM_AW-1:0]];
        if (ins.op == OP_HALT) begin
            return;
        end
        ea = m_regs[ins.rs] + {{16{ins.imm[15]}}, ins.imm};
        case (ins.op)
            OP_ADD: begin
                if (ins.imm[15:11] != 0) begin
                    m_regs[ins.imm[15:11]] = m_regs[ins.rs] + m_regs[ins.rt];
                end
            end
            OP_ADDI: begin
                if (ins.rt != 0) begin
                    m_regs[ins.rt] = ea;
                end
            end
            OP_LW: begin
                if (ins.rt != 0) begin
                    m_regs[ins.rt] = m_dmem[ea[DM_AW-1:0]];
                end
            end
            OP_SW: begin
                m_dmem[ea[DM_AW-1:0]] = m_regs[ins.rt];
            end
            default: begin
            end
        endcase
        m_pc++;
    endtask

    task automatic model_run();
        while (m_imem[m_pc[IM_AW-1:0]].op != OP_HALT) begin
            model_step();
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the strobe is taken
    task automatic send_byte(input logic [NB_BYTE-1:0] b);
        int gap;
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
        rx_data = b;
        rx_done = 1'b1;
        @(posedge clock);
        #1;
        rx_done = 1'b0;
    endtask

    task automatic load_program(input instr_t prog [$]);
        word_t w;
        send_byte(CMD_LOAD);
        for (int i = 0; i < prog.size(); i++) begin
            w = prog[i];
            for (int b = 0; b < 4; b++) begin
                send_byte(w[8*b +: 8]);
            end
            m_imem[i] = prog[i];
        end
        m_pc = 0;
    endtask

    task automatic run_command(input logic [NB_BYTE-1:0] cmd);
        dump_q.delete();
        send_byte(cmd);
        do begin
            @(negedge clock);
        end while (state != ST_IDLE);
        @(posedge clock);
        #1;
    endtask

    function automatic word_t dumped_word(input int w);
        return {dump_q[4*w+3], dump_q[4*w+2], dump_q[4*w+1], dump_q[4*w]};
    endfunction

    function automatic word_t expected_word(input int w);
        if (w == 0) begin
            return word_t'(m_pc);
        end
        if (w <= 2**RB_AW) begin
            return m_regs[w-1];
        end
        return m_dmem[w-1-2**RB_AW];
    endfunction

    task automatic check_dump(input string name);
        word_t got;
        assert (dump_q.size() == DUMP_BYTES) else begin
            $display("FAILED %s dump length expected %0d actual %0d",
                     name, DUMP_BYTES, dump_q.size());
            test_errs++;
        end
        if (dump_q.size() >= DUMP_BYTES) begin
            for (int w = 0; w < DUMP_BYTES / 4; w++) begin
                got = dumped_word(w);
                assert (got == expected_word(w)) else begin
                    $display("FAILED %s word %0d expected %08h actual %08h",
                             name, w, expected_word(w), got);
                    test_errs++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            n_pass++;
            $display("%-14s passed", name);
        end else begin
            n_fail++;
            $display("%-14s %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin : main
        instr_t prog_a [$];
        instr_t prog_b [$];
        instr_t prog_c [$];
        int     chk_errs;

        void'($urandom(32'h96cd));
        rst_n     = 1'b0;
        rx_done   = 1'b0;
        rx_data   = '0;
        tx_done   = 1'b0;
        max_delay = 6;
        test_errs = 0;
        n_pass    = 0;
        n_fail    = 0;
        m_pc      = 0;
        for (int i = 0; i < 2**IM_AW; i++) begin
            m_imem[i] = '0;
        end
        for (int i = 0; i < 2**RB_AW; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 2**DM_AW; i++) begin
            m_dmem[i] = '0;
        end

        // ADD carries rd in imm[15:11]
        prog_a = {enc(OP_ADDI, 0, 1, 5), enc(OP_ADDI, 0, 2, -3), enc(OP_ADD, 1, 2, 3 << 11),
                  enc(OP_SW, 0, 3, 4), enc(OP_SW, 1, 1, 1), enc(OP_LW, 0, 4, 4),
                  enc(OP_ADDI, 1, 0, 7), enc(OP_ADD, 4, 4, 5 << 11), enc(OP_HALT, 0, 0, 0)};
        prog_b = {enc(OP_ADDI, 6, 6, 1), enc(OP_ADD, 6, 3, 7 << 11), enc(OP_SW, 6, 7, 9),
                  enc(OP_LW, 0, 8, 6), enc(OP_HALT, 0, 0, 0)};
        prog_c = {enc(OP_ADDI, 0, 9, 100), enc(OP_SW, 0, 9, 20), enc(OP_ADDI, 1, 1, 1),
                  enc(OP_LW, 0, 10, 10), enc(OP_HALT, 0, 0, 0)};

        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(posedge clock);
        #1;

        load_program(prog_a);
        run_command(CMD_RUN);
        model_run();
        check_dump("load_run");
        finish_test("load_run");

        load_program(prog_b);
        for (int k = 1; k <= 3; k++) begin
            run_command(CMD_STEP);
            model_step();
            check_dump("step");
            assert (dumped_word(0) == word_t'(k)) else begin
                $display("FAILED step pc expected %0d actual %0d", k, dumped_word(0));
                test_errs++;
            end
        end
        finish_test("step");

        // the model stays put across the step, so both dumps must match it
        run_command(CMD_RUN);
        model_run();
        check_dump("halt_sticks");
        run_command(CMD_STEP);
        check_dump("halt_sticks");
        finish_test("halt_sticks");

        max_delay = 20;
        load_program(prog_a);
        run_command(CMD_RUN);
        model_run();
        check_dump("backpressure");
        max_delay = 6;
        finish_test("backpressure");

        // 'x' is no command
        send_byte(8'h78);
        repeat (3) begin
            @(posedge clock);
            #1;
        end
        assert (state == ST_IDLE) else begin
            $display("FAILED reload_ignore state expected %0d actual %0d", ST_IDLE, state);
            test_errs++;
        end
        load_program(prog_c);
        run_command(CMD_RUN);
        model_run();
        check_dump("reload_ignore");
        finish_test("reload_ignore");

        chk_errs = i_top_of_tops.u_top_of_tops_checker.n_fail;
        $display("tests passed %0d, failed %0d, checker errors %0d", n_pass, n_fail, chk_errs);
        if (n_fail == 0 && chk_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb/top_of_tops_checker.sv
`timescale 1ns/1ps

module top_of_tops_checker
    import dbg_pkg::*;
(
    input logic                i_clock,
    input logic                i_rst_n,
    input logic                i_tx_start,
    input logic                i_tx_done,
    input logic [NB_BYTE-1:0]  i_tx_data,
    input logic [NB_STATE-1:0] i_state,
    input logic                i_exec,
    input logic                i_halt,
    input logic                i_pc_clear,
    input word_t               i_pc
);

    logic awaiting_done;
    int   n_fail = 0;

    // a byte is outstanding from the cycle after its start pulse until tx_done
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            awaiting_done <= 1'b0;
        end else if (i_tx_start) begin
            awaiting_done <= 1'b1;
        end else if (i_tx_done) begin
            awaiting_done <= 1'b0;
        end
    end

    start_single_cycle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_tx_start |=> !i_tx_start)
    else begin
        $error("o_tx_start high for two cycles");
        n_fail++;
    end

    start_waits_done: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        awaiting_done |-> !i_tx_start)
    else begin
        $error("o_tx_start before i_tx_done of the previous byte");
        n_fail++;
    end

    data_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        ((i_tx_start || awaiting_done) && !i_tx_done) |=> $stable(i_tx_data))
    else begin
        $error("o_tx_data changed while the byte was outstanding");
        n_fail++;
    end

    no_exec_in_load: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_state == ST_LOAD) |-> !i_exec)
    else begin
        $error("exec high during ST_LOAD");
        n_fail++;
    end

    pc_held_on_halt: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_halt && !i_pc_clear) |=> $stable(i_pc))
    else begin
        $error("pc moved while halt was high");
        n_fail++;
    end

endmodule

bind top_of_tops top_of_tops_checker u_top_of_tops_checker (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_tx_start (o_tx_start),
    .i_tx_done  (i_tx_done),
    .i_tx_data  (o_tx_data),
    .i_state    (o_state),
    .i_exec     (exec),
    .i_halt     (halt),
    .i_pc_clear (pc_clear),
    .i_pc       (pc)
);

// File: hdl/top_of_tops.sv
`timescale 1ns/1ps

module top_of_tops
    import dbg_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_rx_done,
    input  logic [NB_BYTE-1:0]  i_rx_data,
    input  logic                i_tx_done,
    output logic [NB_STATE-1:0] o_state,
    output logic [NB_BYTE-1:0]  o_tx_data,
    output logic                o_tx_start
);

    im_wr_t  im_wr;
    logic    exec;
    logic    pc_clear;
    dbg_rd_t dbg_rd;
    logic    halt;
    word_t   pc;
    word_t   rb_data;
    word_t   dm_data;

    debug_unit u_debug_unit (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rx_done  (i_rx_done),
        .i_rx_data  (i_rx_data),
        .i_tx_done  (i_tx_done),
        .i_halt     (halt),
        .i_pc       (pc),
        .i_rb_data  (rb_data),
        .i_dm_data  (dm_data),
        .o_im_wr    (im_wr),
        .o_exec     (exec),
        .o_pc_clear (pc_clear),
        .o_dbg_rd   (dbg_rd),
        .o_tx_data  (o_tx_data),
        .o_tx_start (o_tx_start),
        .o_state    (o_state)
    );

    data_path u_data_path (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_exec     (exec),
        .i_pc_clear (pc_clear),
        .i_im_wr    (im_wr),
        .i_dbg_rd   (dbg_rd),
        .o_halt     (halt),
        .o_pc       (pc),
        .o_rb_data  (rb_data),
        .o_dm_data  (dm_data)
    );

endmodule

// File: hdl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit
    import dbg_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_rx_done,
    input  logic [NB_BYTE-1:0] i_rx_data,
    input  logic               i_tx_done,
    input  logic               i_halt,
    input  word_t              i_pc,
    input  word_t              i_rb_data,
    input  word_t              i_dm_data,
    output im_wr_t             o_im_wr,
    output logic               o_exec,
    output logic               o_pc_clear,
    output dbg_rd_t            o_dbg_rd,
    output logic [NB_BYTE-1:0] o_tx_data,
    output logic               o_tx_start,
    output dbg_state_e         o_state
);

    dbg_state_e           state_q;
    logic [1:0]           byte_cnt;
    logic [IM_AW-1:0]     load_ptr;
    logic                 im_we_q;
    logic                 pc_clear_q;
    logic [NB_DUMP-1:0]   dump_cnt;

    logic [23:0]          word_buf;
    instr_t               load_word;
    instr_t               im_data_q;

    logic [NB_DUMP-3:0]   word_idx;
    logic [NB_DUMP-3:0]   word_m1;
    word_t                sel_word;

    // fourth byte completes the word, lsb first
    assign load_word = {i_rx_data, word_buf};

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= ST_IDLE;
            byte_cnt   <= '0;
            load_ptr   <= '0;
            im_we_q    <= 1'b0;
            pc_clear_q <= 1'b0;
            dump_cnt   <= '0;
        end else begin
            im_we_q    <= 1'b0;
            pc_clear_q <= 1'b0;
            // pointer moves on the cycle the word lands in imem
            if (im_we_q) begin
                load_ptr <= load_ptr + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: begin
                                pc_clear_q <= 1'b1;
                                load_ptr   <= '0;
                                byte_cnt   <= '0;
                                state_q    <= ST_LOAD;
                            end
                            CMD_RUN: begin
                                state_q <= ST_RUN;
                            end
                            CMD_STEP: begin
                                state_q <= i_halt ? ST_DUMP : ST_STEP;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (i_rx_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            im_we_q <= 1'b1;
                            if (load_word.op == OP_HALT) begin
                                state_q <= ST_IDLE;
                            end
                        end
                    end
                end
                ST_RUN: begin
                    if (i_halt) begin
                        state_q <= ST_DUMP;
                    end
                end
                ST_STEP: begin
                    state_q <= ST_DUMP;
                end
                ST_DUMP: begin
                    state_q <= ST_WAIT_TX;
                end
                ST_WAIT_TX: begin
                    if (i_tx_done) begin
                        if (dump_cnt == NB_DUMP'(DUMP_BYTES - 1)) begin
                            dump_cnt <= '0;
                            state_q  <= ST_IDLE;
                        end else begin
                            dump_cnt <= dump_cnt + 1'b1;
                            state_q  <= ST_DUMP;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // load word assembly
    always_ff @(posedge i_clock) begin
        if (i_rx_done && (state_q == ST_LOAD)) begin
            if (byte_cnt == 2'd3) begin
                im_data_q <= load_word;
            end else begin
                word_buf[{byte_cnt, 3'b000} +: NB_BYTE] <= i_rx_data;
            end
        end
    end

    assign o_im_wr = '{we: im_we_q, addr: load_ptr, data: im_data_q};

    assign o_exec = ((state_q == ST_RUN) && !i_halt) || (state_q == ST_STEP);

    assign o_pc_clear = pc_clear_q;

    // word 0 is the pc, 1..32 registers, 33..64 data memory
    assign word_idx = dump_cnt[NB_DUMP-1:2];
    assign word_m1  = word_idx - 1'b1;
    assign o_dbg_rd = '{rb_addr: word_m1[RB_AW-1:0], dm_addr: word_m1[DM_AW-1:0]};

    always_comb begin
        if (word_idx == '0) begin
            sel_word = i_pc;
        end else if (!word_m1[RB_AW]) begin
            sel_word = i_rb_data;
        end else begin
            sel_word = i_dm_data;
        end
    end

    // held until the counter moves on tx_done
    assign o_tx_data  = sel_word[{dump_cnt[1:0], 3'b000} +: NB_BYTE];
    assign o_tx_start = (state_q == ST_DUMP);
    assign o_state    = state_q;

endmodule

// File: hdl/data_path.sv
`timescale 1ns/1ps

module data_path
    import dbg_pkg::*;
(
    input  logic    i_clock,
    input  logic    i_rst_n,
    input  logic    i_exec,
    input  logic    i_pc_clear,
    input  im_wr_t  i_im_wr,
    input  dbg_rd_t i_dbg_rd,
    output logic    o_halt,
    output word_t   o_pc,
    output word_t   o_rb_data,
    output word_t   o_dm_data
);

    word_t            pc_q;
    instr_t           instr;
    logic             halt;

    logic [RB_AW-1:0] ra_addr;
    word_t            rs_data;
    word_t            rt_data;

    word_t            imm_sext;
    word_t            alu_b;
    word_t            alu_sum;

    logic             rb_we;
    logic [RB_AW-1:0] wa_addr;
    logic             wb_mem;
    word_t            wb_data;

    logic             dm_we;
    logic [DM_AW-1:0] dm_raddr;
    word_t            dm_rdata;

    assign halt = (instr.op == OP_HALT);

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= '0;
        end else if (i_pc_clear) begin
            pc_q <= '0;
        end else if (i_exec && !halt) begin
            pc_q <= pc_q + 32'd1;
        end
    end

    mem_block #(
        .T  (instr_t),
        .AW (IM_AW)
    ) u_imem (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_we    (i_im_wr.we),
        .i_waddr (i_im_wr.addr),
        .i_wdata (i_im_wr.data),
        .i_raddr (pc_q[IM_AW-1:0]),
        .o_rdata (instr)
    );

    // debug side owns port A and the data read while the core is stopped
    always_comb begin
        if (!i_exec) begin
            ra_addr  = i_dbg_rd.rb_addr;
            dm_raddr = i_dbg_rd.dm_addr;
        end else begin
            ra_addr  = instr.rs;
            dm_raddr = alu_sum[DM_AW-1:0];
        end
    end

    register_bank u_register_bank (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_ra_addr (ra_addr),
        .i_rb_addr (instr.rt),
        .i_we      (rb_we),
        .i_wa_addr (wa_addr),
        .i_wdata   (wb_data),
        .o_ra_data (rs_data),
        .o_rb_data (rt_data)
    );

    assign imm_sext = {{16{instr.imm[15]}}, instr.imm};
    assign alu_b    = (instr.op == OP_ADD) ? rt_data : imm_sext;
    assign alu_sum  = rs_data + alu_b;

    // decode, unknown opcodes and HALT write nothing
    always_comb begin
        rb_we   = 1'b0;
        dm_we   = 1'b0;
        wb_mem  = 1'b0;
        wa_addr = instr.rt;
        case (instr.op)
            OP_ADD: begin
                rb_we   = i_exec;
                wa_addr = instr.imm[15:11];
            end
            OP_ADDI: begin
                rb_we = i_exec;
            end
            OP_LW: begin
                rb_we  = i_exec;
                wb_mem = 1'b1;
            end
            OP_SW: begin
                dm_we = i_exec;
            end
            default: begin
            end
        endcase
    end

    assign wb_data = wb_mem ? dm_rdata : alu_sum;

    mem_block #(
        .T  (word_t),
        .AW (DM_AW)
    ) u_dmem (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_we    (dm_we),
        .i_waddr (alu_sum[DM_AW-1:0]),
        .i_wdata (rt_data),
        .i_raddr (dm_raddr),
        .o_rdata (dm_rdata)
    );

    assign o_halt    = halt;
    assign o_pc      = pc_q;
    assign o_rb_data = rs_data;
    assign o_dm_data = dm_rdata;

endmodule

// File: hdl/register_bank.sv
`timescale 1ns/1ps

module register_bank
    import dbg_pkg::*;
(
    input  logic             i_clock,
    input  logic             i_rst_n,
    input  logic [RB_AW-1:0] i_ra_addr,
    input  logic [RB_AW-1:0] i_rb_addr,
    input  logic             i_we,
    input  logic [RB_AW-1:0] i_wa_addr,
    input  word_t            i_wdata,
    output word_t            o_ra_data,
    output word_t            o_rb_data
);

    word_t regs [2**RB_AW];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**RB_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wa_addr != '0)) begin
            // r0 is never written, so it stays zero after reset
            regs[i_wa_addr] <= i_wdata;
        end
    end

    assign o_ra_data = regs[i_ra_addr];
    assign o_rb_data = regs[i_rb_addr];

endmodule

// File: hdl/mem_block.sv
`timescale 1ns/1ps

module mem_block #(
    parameter type T  = logic [31:0],
    parameter int  AW = 5
) (
    input  logic          i_clock,
    input  logic          i_rst_n,
    input  logic          i_we,
    input  logic [AW-1:0] i_waddr,
    input  T              i_wdata,
    input  logic [AW-1:0] i_raddr,
    output T              o_rdata
);

    T mem [2**AW];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**AW; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // asynchronous read
    assign o_rdata = mem[i_raddr];

endmodule

// File: hdl/dbg_pkg.sv
package dbg_pkg;

    localparam int NB_BYTE  = 8;
    localparam int NB_WORD  = 32;
    localparam int IM_AW    = 8;
    localparam int DM_AW    = 5;
    localparam int RB_AW    = 5;
    localparam int NB_STATE = 4;
    localparam int NB_DUMP  = 9;

    // pc word, then the register bank, then data memory
    localparam int DUMP_BYTES = 4 + 4 * (2**RB_AW) + 4 * (2**DM_AW);

    typedef logic [NB_WORD-1:0] word_t;

    // for ADD the destination sits in imm[15:11]
    typedef struct packed {
        logic [5:0]       op;
        logic [RB_AW-1:0] rs;
        logic [RB_AW-1:0] rt;
        logic [15:0]      imm;
    } instr_t;

    localparam logic [5:0] OP_ADD  = 6'h00;
    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_LW   = 6'h23;
    localparam logic [5:0] OP_SW   = 6'h2b;
    localparam logic [5:0] OP_HALT = 6'h3f;

    // ascii 'L', 'C', 'S'
    localparam logic [NB_BYTE-1:0] CMD_LOAD = 8'h4c;
    localparam logic [NB_BYTE-1:0] CMD_RUN  = 8'h43;
    localparam logic [NB_BYTE-1:0] CMD_STEP = 8'h53;

    typedef enum logic [NB_STATE-1:0] {
        ST_IDLE    = 4'd0,
        ST_LOAD    = 4'd1,
        ST_RUN     = 4'd2,
        ST_STEP    = 4'd3,
        ST_DUMP    = 4'd4,
        ST_WAIT_TX = 4'd5
    } dbg_state_e;

    typedef struct packed {
        logic             we;
        logic [IM_AW-1:0] addr;
        instr_t           data;
    } im_wr_t;

    typedef struct packed {
        logic [RB_AW-1:0] rb_addr;
        logic [DM_AW-1:0] dm_addr;
    } dbg_rd_t;

endpackage
